// ==== common/bus_pkg.sv ====
package bus_pkg;

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int RESP_WIDTH = 2;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [RESP_WIDTH-1:0] resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // core-local timer window, 64 KiB
    localparam addr_t CLINT_BASE      = 32'h0200_0000;
    localparam addr_t CLINT_MASK      = 32'hFFFF_0000;
    localparam addr_t MTIME_LO_OFFSET = 32'h0000_BFF8;
    localparam addr_t MTIME_HI_OFFSET = 32'h0000_BFFC;

    localparam int MTIME_WIDTH = 64;

    typedef enum logic {
        OWNER_FETCH = 1'b0,
        OWNER_LOAD  = 1'b1
    } owner_e;

    typedef enum logic {
        TARGET_MEM   = 1'b0,
        TARGET_CLINT = 1'b1
    } target_e;

    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,
        ST_ADDR = 2'b01,
        ST_DATA = 2'b10
    } arb_state_e;

endpackage

// ==== common/rd_bus_if.sv ====
`timescale 1ns/1ps

interface rd_bus_if;

    // address channel
    logic              arvalid;
    logic              arready;
    bus_pkg::addr_t    araddr;

    // data channel, single beat
    logic              rvalid;
    logic              rready;
    bus_pkg::data_t    rdata;
    bus_pkg::resp_t    rresp;

    modport manager (
        output arvalid,
        output araddr,
        output rready,
        input  arready,
        input  rvalid,
        input  rdata,
        input  rresp
    );

    modport subordinate (
        input  arvalid,
        input  araddr,
        input  rready,
        output arready,
        output rvalid,
        output rdata,
        output rresp
    );

endinterface

// ==== arbiter/read_arbiter_fsm.sv ====
`timescale 1ns/1ps

module read_arbiter_fsm (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                fetch_req,
    input  logic                load_req,
    input  bus_pkg::addr_t      fetch_addr,
    input  bus_pkg::addr_t      load_addr,
    input  logic                ar_done,
    input  logic                r_done,
    output bus_pkg::owner_e     owner,
    output bus_pkg::target_e    target,
    output bus_pkg::arb_state_e state
);

    import bus_pkg::*;

    arb_state_e state_q;
    arb_state_e state_d;
    owner_e     owner_q;
    owner_e     owner_d;
    target_e    target_q;
    target_e    target_d;
    addr_t      grant_addr;
    logic       any_req;

    assign any_req = fetch_req | load_req;

    // load side wins a tie
    always_comb begin
        if (load_req) begin
            owner_d    = OWNER_LOAD;
            grant_addr = load_addr;
        end else begin
            owner_d    = OWNER_FETCH;
            grant_addr = fetch_addr;
        end
    end

    always_comb begin
        if ((grant_addr & CLINT_MASK) == CLINT_BASE) begin
            target_d = TARGET_CLINT;
        end else begin
            target_d = TARGET_MEM;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (any_req) begin
                    state_d = ST_ADDR;
                end
            end
            ST_ADDR: begin
                if (ar_done) begin
                    state_d = ST_DATA;
                end
            end
            ST_DATA: begin
                // owner back-pressure keeps us here
                if (r_done) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // grant and target only change when leaving idle
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            owner_q  <= OWNER_FETCH;
            target_q <= TARGET_MEM;
        end else if (state_q == ST_IDLE && any_req) begin
            owner_q  <= owner_d;
            target_q <= target_d;
        end
    end

    assign owner  = owner_q;
    assign target = target_q;
    assign state  = state_q;

endmodule

// ==== arbiter/read_path_mux.sv ====
`timescale 1ns/1ps

module read_path_mux (
    rd_bus_if.subordinate       fetch_bus,
    rd_bus_if.subordinate       load_bus,
    rd_bus_if.manager           mem_bus,
    rd_bus_if.manager           clint_bus,
    input  bus_pkg::owner_e     owner,
    input  bus_pkg::target_e    target,
    input  bus_pkg::arb_state_e state,
    output logic                ar_done,
    output logic                r_done
);

    import bus_pkg::*;

    logic  own_arvalid;
    logic  own_rready;
    addr_t own_araddr;
    logic  tgt_arready;
    logic  tgt_rvalid;
    data_t tgt_rdata;
    resp_t tgt_rresp;

    assign own_arvalid = (owner == OWNER_LOAD) ? load_bus.arvalid : fetch_bus.arvalid;
    assign own_rready  = (owner == OWNER_LOAD) ? load_bus.rready  : fetch_bus.rready;
    assign own_araddr  = (owner == OWNER_LOAD) ? load_bus.araddr  : fetch_bus.araddr;

    assign tgt_arready = (target == TARGET_CLINT) ? clint_bus.arready : mem_bus.arready;
    assign tgt_rvalid  = (target == TARGET_CLINT) ? clint_bus.rvalid  : mem_bus.rvalid;
    assign tgt_rdata   = (target == TARGET_CLINT) ? clint_bus.rdata   : mem_bus.rdata;
    assign tgt_rresp   = (target == TARGET_CLINT) ? clint_bus.rresp   : mem_bus.rresp;

    // payload fans out, only the handshakes are steered
    assign mem_bus.araddr   = own_araddr;
    assign clint_bus.araddr = own_araddr;
    assign fetch_bus.rdata  = tgt_rdata;
    assign load_bus.rdata   = tgt_rdata;
    assign fetch_bus.rresp  = tgt_rresp;
    assign load_bus.rresp   = tgt_rresp;

    always_comb begin
        mem_bus.arvalid    = 1'b0;
        clint_bus.arvalid  = 1'b0;
        fetch_bus.arready  = 1'b0;
        load_bus.arready   = 1'b0;
        fetch_bus.rvalid   = 1'b0;
        load_bus.rvalid    = 1'b0;
        mem_bus.rready     = 1'b0;
        clint_bus.rready   = 1'b0;
        if (state == ST_ADDR) begin
            if (target == TARGET_CLINT) begin
                clint_bus.arvalid = own_arvalid;
            end else begin
                mem_bus.arvalid = own_arvalid;
            end
            if (owner == OWNER_LOAD) begin
                load_bus.arready = tgt_arready;
            end else begin
                fetch_bus.arready = tgt_arready;
            end
        end else if (state == ST_DATA) begin
            if (owner == OWNER_LOAD) begin
                load_bus.rvalid = tgt_rvalid;
            end else begin
                fetch_bus.rvalid = tgt_rvalid;
            end
            if (target == TARGET_CLINT) begin
                clint_bus.rready = own_rready;
            end else begin
                mem_bus.rready = own_rready;
            end
        end
    end

    assign ar_done = (state == ST_ADDR) && own_arvalid && tgt_arready;
    assign r_done  = (state == ST_DATA) && tgt_rvalid && own_rready;

endmodule

// ==== clint/clint_timer.sv ====
`timescale 1ns/1ps

module clint_timer (
    input  logic          clock,
    input  logic          rst_n,
    rd_bus_if.subordinate bus
);

    import bus_pkg::*;

    logic [MTIME_WIDTH-1:0] mtime;
    logic                   rvalid_q;
    data_t                  rdata_q;
    addr_t                  offset;
    logic                   ar_fire;
    logic                   r_fire;

    assign offset  = bus.araddr & ~CLINT_MASK;
    assign ar_fire = bus.arvalid && bus.arready;
    assign r_fire  = rvalid_q && bus.rready;

    // free-running machine time
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            mtime <= '0;
        end else begin
            mtime <= mtime + 1'b1;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
        end else if (ar_fire) begin
            rvalid_q <= 1'b1;
        end else if (r_fire) begin
            rvalid_q <= 1'b0;
        end
    end

    // sample the counter as seen at the address edge
    always_ff @(posedge clock) begin
        if (ar_fire) begin
            case (offset)
                MTIME_LO_OFFSET: rdata_q <= mtime[DATA_WIDTH-1:0];
                MTIME_HI_OFFSET: rdata_q <= mtime[MTIME_WIDTH-1:DATA_WIDTH];
                default:         rdata_q <= '0;
            endcase
        end
    end

    // one outstanding read at a time
    assign bus.arready = !rvalid_q;
    assign bus.rvalid  = rvalid_q;
    assign bus.rdata   = rdata_q;
    assign bus.rresp   = RESP_OKAY;

endmodule

// ==== logic/bus_read_subsystem.sv ====
`timescale 1ns/1ps

module bus_read_subsystem (
    input  logic           clock,
    input  logic           rst_n,

    input  logic           fetch_arvalid,
    output logic           fetch_arready,
    input  bus_pkg::addr_t fetch_araddr,
    output logic           fetch_rvalid,
    input  logic           fetch_rready,
    output bus_pkg::data_t fetch_rdata,
    output bus_pkg::resp_t fetch_rresp,

    input  logic           load_arvalid,
    output logic           load_arready,
    input  bus_pkg::addr_t load_araddr,
    output logic           load_rvalid,
    input  logic           load_rready,
    output bus_pkg::data_t load_rdata,
    output bus_pkg::resp_t load_rresp,

    output logic           mem_arvalid,
    input  logic           mem_arready,
    output bus_pkg::addr_t mem_araddr,
    input  logic           mem_rvalid,
    output logic           mem_rready,
    input  bus_pkg::data_t mem_rdata,
    input  bus_pkg::resp_t mem_rresp
);

    import bus_pkg::*;

    owner_e     owner;
    target_e    target;
    arb_state_e state;
    logic       ar_done;
    logic       r_done;

    rd_bus_if fetch_bus ();
    rd_bus_if load_bus ();
    rd_bus_if mem_bus ();
    rd_bus_if clint_bus ();

    // instruction fetch requester
    assign fetch_bus.arvalid = fetch_arvalid;
    assign fetch_bus.araddr  = fetch_araddr;
    assign fetch_bus.rready  = fetch_rready;
    assign fetch_arready     = fetch_bus.arready;
    assign fetch_rvalid      = fetch_bus.rvalid;
    assign fetch_rdata       = fetch_bus.rdata;
    assign fetch_rresp       = fetch_bus.rresp;

    // load-store requester
    assign load_bus.arvalid = load_arvalid;
    assign load_bus.araddr  = load_araddr;
    assign load_bus.rready  = load_rready;
    assign load_arready     = load_bus.arready;
    assign load_rvalid      = load_bus.rvalid;
    assign load_rdata       = load_bus.rdata;
    assign load_rresp       = load_bus.rresp;

    // external read master
    assign mem_arvalid       = mem_bus.arvalid;
    assign mem_araddr        = mem_bus.araddr;
    assign mem_rready        = mem_bus.rready;
    assign mem_bus.arready   = mem_arready;
    assign mem_bus.rvalid    = mem_rvalid;
    assign mem_bus.rdata     = mem_rdata;
    assign mem_bus.rresp     = mem_rresp;

    read_arbiter_fsm u_arbiter_fsm (
        .clock      (clock),
        .rst_n      (rst_n),
        .fetch_req  (fetch_bus.arvalid),
        .load_req   (load_bus.arvalid),
        .fetch_addr (fetch_bus.araddr),
        .load_addr  (load_bus.araddr),
        .ar_done    (ar_done),
        .r_done     (r_done),
        .owner      (owner),
        .target     (target),
        .state      (state)
    );

    read_path_mux u_path_mux (
        .fetch_bus  (fetch_bus.subordinate),
        .load_bus   (load_bus.subordinate),
        .mem_bus    (mem_bus.manager),
        .clint_bus  (clint_bus.manager),
        .owner      (owner),
        .target     (target),
        .state      (state),
        .ar_done    (ar_done),
        .r_done     (r_done)
    );

    clint_timer u_clint (
        .clock      (clock),
        .rst_n      (rst_n),
        .bus        (clint_bus.subordinate)
    );

endmodule

// ==== sim/tb_mem_model.sv ====
`timescale 1ns/1ps

module tb_mem_model #(
    parameter int             seed_init = 1,
    parameter bus_pkg::data_t xor_key   = '0
) (
    input  logic           clock,
    input  logic           rst_n,
    input  logic           arvalid,
    output logic           arready,
    input  bus_pkg::addr_t araddr,
    output logic           rvalid,
    input  logic           rready,
    output bus_pkg::data_t rdata,
    output bus_pkg::resp_t rresp
);

    import bus_pkg::*;

    integer seed;
    addr_t  addr;
    int     delay;

    // wait 0 to 6 falling edges
    task automatic random_wait();
        delay = $unsigned($random(seed)) % 7;
        repeat (delay) @(negedge clock);
    endtask

    initial begin
        seed    = seed_init;
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        rresp   = RESP_OKAY;
        forever begin
            @(posedge clock);
            if (rst_n && arvalid) begin
                // address is held until the transfer
                addr = araddr;
                @(negedge clock);
                random_wait();
                arready = 1'b1;
                @(posedge clock);
                @(negedge clock);
                arready = 1'b0;
                random_wait();
                rvalid = 1'b1;
                rdata  = addr ^ xor_key;
                rresp  = addr[4] ? RESP_SLVERR : RESP_OKAY;
                do begin
                    @(posedge clock);
                end while (!rready);
                @(negedge clock);
                rvalid = 1'b0;
            end
        end
    end

endmodule

// ==== sim/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;

    import bus_pkg::*;

    localparam int    num_trans   = 300;
    localparam int    cycle_limit = num_trans * 30;
    localparam data_t mem_key     = 32'h5A3C_96E1;

    logic        clock;
    logic        rst_n;
    logic        fetch_arvalid, fetch_arready, fetch_rvalid, fetch_rready;
    addr_t       fetch_araddr;
    data_t       fetch_rdata;
    resp_t       fetch_rresp;
    logic        load_arvalid, load_arready, load_rvalid, load_rready;
    addr_t       load_araddr;
    data_t       load_rdata;
    resp_t       load_rresp;
    logic        mem_arvalid, mem_arready, mem_rvalid, mem_rready;
    addr_t       mem_araddr;
    data_t       mem_rdata;
    resp_t       mem_rresp;
    integer      seed = 32'h010b_357a;
    integer      fetch_seed;
    integer      load_seed;
    logic [63:0] edge_count;
    int          cycle_count;

    bus_read_subsystem u_dut (.*);

    tb_mem_model #(.seed_init(32'h010b_357a + 2), .xor_key(mem_key)) u_mem (
        .clock   (clock),
        .rst_n   (rst_n),
        .arvalid (mem_arvalid),
        .arready (mem_arready),
        .araddr  (mem_araddr),
        .rvalid  (mem_rvalid),
        .rready  (mem_rready),
        .rdata   (mem_rdata),
        .rresp   (mem_rresp)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // machine time as seen by the testbench
    always @(posedge clock) begin
        if (rst_n) begin
            edge_count <= edge_count + 1;
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout: reads still open after %0d cycles", cycle_limit);
        $display("ERRORS FOUND");
        $fatal(1);
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    function automatic integer next_random(input bit is_load);
        if (is_load) begin
            return $random(load_seed);
        end else begin
            return $random(fetch_seed);
        end
    endfunction

    // mostly memory, three in eight reads hit the timer window
    function automatic addr_t random_addr(input bit is_load);
        addr_t addr;
        int    pick;
        pick = next_random(is_load) & 7;
        addr = next_random(is_load) & 32'hFFFF_FFFC;
        if (pick == 0) begin
            addr = CLINT_BASE | MTIME_LO_OFFSET;
        end else if (pick == 1) begin
            addr = CLINT_BASE | MTIME_HI_OFFSET;
        end else if (pick == 2) begin
            addr = CLINT_BASE | (addr & 32'h0000_FFFC);
        end else if ((addr & CLINT_MASK) == CLINT_BASE) begin
            addr = addr ^ 32'h1000_0000;
        end
        return addr;
    endfunction

    function automatic data_t expected_data(input addr_t addr, input logic [63:0] mtime);
        addr_t offset;
        offset = addr & ~CLINT_MASK;
        if ((addr & CLINT_MASK) != CLINT_BASE) begin
            return addr ^ mem_key;
        end else if (offset == MTIME_LO_OFFSET) begin
            return mtime[31:0];
        end else if (offset == MTIME_HI_OFFSET) begin
            return mtime[63:32];
        end
        return '0;
    endfunction

    function automatic resp_t expected_resp(input addr_t addr);
        if ((addr & CLINT_MASK) != CLINT_BASE && addr[4]) begin
            return RESP_SLVERR;
        end
        return RESP_OKAY;
    endfunction

    task automatic drive_port(input bit is_load, input logic valid, input addr_t addr,
                              input logic ready);
        if (is_load) begin
            load_arvalid = valid;
            load_araddr  = addr;
            load_rready  = ready;
        end else begin
            fetch_arvalid = valid;
            fetch_araddr  = addr;
            fetch_rready  = ready;
        end
    endtask

    task automatic check_idle_outputs();
        check_value("fetch_arready", fetch_arready, 0);
        check_value("load_arready", load_arready, 0);
        check_value("fetch_rvalid", fetch_rvalid, 0);
        check_value("load_rvalid", load_rvalid, 0);
        check_value("mem_arvalid", mem_arvalid, 0);
        check_value("mem_rready", mem_rready, 0);
    endtask

    task automatic do_read(input bit is_load, input addr_t addr);
        string       who;
        logic        is_clint;
        logic        ready;
        logic        got_rvalid;
        logic [63:0] mtime;
        bit          first;
        who      = is_load ? "load" : "fetch";
        is_clint = (addr & CLINT_MASK) == CLINT_BASE;
        @(negedge clock);
        drive_port(is_load, 1'b1, addr, 1'b0);
        // no response may show up before the address transfer
        do begin
            @(posedge clock);
            check_value({who, "_rvalid"}, is_load ? load_rvalid : fetch_rvalid, 0);
        end while (!(is_load ? load_arready : fetch_arready));
        mtime = edge_count;
        if (is_clint) begin
            check_value("mem_arvalid", mem_arvalid, 0);
        end else begin
            check_value("mem_araddr", mem_araddr, addr);
        end
        first = 1'b1;
        do begin
            @(negedge clock);
            ready = (next_random(is_load) & 3) != 0;
            drive_port(is_load, 1'b0, addr, ready);
            @(posedge clock);
            check_value("mem_arvalid", mem_arvalid, 0);
            got_rvalid = is_load ? load_rvalid : fetch_rvalid;
            if (is_clint && first) begin
                check_value({who, "_rvalid"}, got_rvalid, 1);
            end
            first = 1'b0;
        end while (!(got_rvalid && ready));
        check_value({who, "_rdata"}, is_load ? load_rdata : fetch_rdata,
                    expected_data(addr, mtime));
        check_value({who, "_rresp"}, is_load ? load_rresp : fetch_rresp, expected_resp(addr));
        @(negedge clock);
        drive_port(is_load, 1'b0, addr, 1'b0);
    endtask

    task automatic run_requester(input bit is_load, input int count);
        int gap;
        repeat (count) begin
            gap = next_random(is_load) & 3;
            repeat (gap) @(negedge clock);
            do_read(is_load, random_addr(is_load));
        end
    endtask

    initial begin
        fetch_seed = seed;
        load_seed  = seed + 1;
        edge_count = '0;
        rst_n      = 1'b0;
        drive_port(1'b0, 1'b0, '0, 1'b0);
        drive_port(1'b1, 1'b0, '0, 1'b0);
        repeat (2) begin
            @(posedge clock);
            check_idle_outputs();
        end
        @(negedge clock);
        rst_n = 1'b1;
        @(posedge clock);
        check_idle_outputs();

        // both ask in the same idle cycle, load must reach memory first
        fork
            do_read(1'b0, 32'h0000_1000);
            do_read(1'b1, 32'h0000_2010);
            begin
                @(posedge clock);
                while (!mem_arvalid) @(posedge clock);
                check_value("mem_araddr", mem_araddr, 32'h0000_2010);
            end
        join

        fork
            run_requester(1'b0, num_trans / 2 - 1);
            run_requester(1'b1, num_trans / 2 - 1);
        join
        @(posedge clock);
        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== Bender.yml ====
package:
  name: bus_read_subsystem

sources:
  - files:
      - common/bus_pkg.sv
      - common/rd_bus_if.sv
      - arbiter/read_arbiter_fsm.sv
      - arbiter/read_path_mux.sv
      - clint/clint_timer.sv
      - logic/bus_read_subsystem.sv
  - target: simulation
    files:
      - sim/tb_mem_model.sv
      - sim/tb_top.sv

// ==== sim.f ====
common/bus_pkg.sv
common/rd_bus_if.sv
arbiter/read_arbiter_fsm.sv
arbiter/read_path_mux.sv
clint/clint_timer.sv
logic/bus_read_subsystem.sv
sim/tb_mem_model.sv
sim/tb_top.sv
